//--- include/fpu_defs_defs.svh
////////////////////////////////////////////////////////////
// FPU configuration
// Pipeline depth and Wishbone register map of the shared
// fused multiply-add unit
////////////////////////////////////////////////////////////

`ifndef FPU_DEFS_DEFS_SVH
`define FPU_DEFS_DEFS_SVH

// Operand registers ahead of the FMA core, legal range 1 to 4
`define FPU_PRE_REGS 1

// Register byte offsets on the slave port
`define FPU_ADDR_OPA  5'h00
`define FPU_ADDR_OPB  5'h04
`define FPU_ADDR_OPC  5'h08
`define FPU_ADDR_CTRL 5'h0C
`define FPU_ADDR_RES  5'h10
`define FPU_ADDR_STAT 5'h14

`endif

//--- src/fpu_pkg.sv
////////////////////////////////////////////////////////////
// FPU types
// Opcode and rounding enums, IEEE status flags and the
// request and response items of the FMA pipeline
////////////////////////////////////////////////////////////

`default_nettype none

package fpu_pkg;

  // Bit 1 negates B, bit 0 negates C
  typedef enum logic [1:0] {
    FMADD  = 2'b00,
    FMSUB  = 2'b01,
    FNMSUB = 2'b10,
    FNMADD = 2'b11
  } fma_op_e;

  // Unlisted encodings round as RNE
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } rnd_mode_e;

  // IEEE exception flags, nv at the MSB
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // Operands as they enter the core
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    rnd_mode_e   rnd;
  } fma_req_t;

  typedef struct packed {
    logic [31:0] res;
    fp_status_t  status;
  } fma_rsp_t;

endpackage

`default_nettype wire

//--- src/fpu_wb_slave.sv
////////////////////////////////////////////////////////////
// FPU Wishbone slave
// Register file for operands, control and result, issues
// one FMA operation per CTRL write and tracks busy/done
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fpu_defs_defs.svh"

module fpu_wb_slave (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Wishbone classic slave port
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [4:0]           wb_adr_i,
  input  logic [31:0]          wb_dat_i,
  input  logic [3:0]           wb_sel_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  // Issue side
  output logic                 fma_en_o,
  output fpu_pkg::fma_req_t    fma_req_o,
  output fpu_pkg::fma_op_e     fma_op_o,
  // Result side
  input  logic                 res_valid_i,
  input  fpu_pkg::fma_rsp_t    res_rsp_i
);

  // Byte enables on wb_sel_i are ignored, writes are full words

  logic                  req_new;
  logic                  wr_ctrl;
  logic                  issue;
  logic                  ack_q;
  logic [31:0]           rdata_d;
  logic [31:0]           rdata_q;
  logic [31:0]           opa_q;
  logic [31:0]           opb_q;
  logic [31:0]           opc_q;
  fpu_pkg::fma_op_e      op_q;
  fpu_pkg::rnd_mode_e    rnd_q;
  logic                  en_q;
  logic                  busy_q;
  logic                  done_q;
  logic [31:0]           res_q;
  fpu_pkg::fp_status_t   stat_q;

  // New access only when no ack is pending, so each access is 2 cycles
  assign req_new = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_ctrl = req_new & wb_we_i & (wb_adr_i == `FPU_ADDR_CTRL);
  // Start while busy is dropped
  assign issue   = wr_ctrl & ~busy_q;

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_adr_i)
      `FPU_ADDR_OPA:  rdata_d = opa_q;
      `FPU_ADDR_OPB:  rdata_d = opb_q;
      `FPU_ADDR_OPC:  rdata_d = opc_q;
      `FPU_ADDR_CTRL: rdata_d = {27'd0, rnd_q, op_q};
      `FPU_ADDR_RES:  rdata_d = res_q;
      `FPU_ADDR_STAT: rdata_d = {25'd0, stat_q, done_q, busy_q};
      default:        rdata_d = '0;
    endcase
  end

  // Ack and read data both land on the edge after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q <= req_new;
      if (req_new && !wb_we_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  // Operand writes, CTRL fields only taken on an accepted issue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opa_q <= '0;
      opb_q <= '0;
      opc_q <= '0;
      op_q  <= fpu_pkg::FMADD;
      rnd_q <= fpu_pkg::RNE;
    end else begin
      if (req_new && wb_we_i) begin
        case (wb_adr_i)
          `FPU_ADDR_OPA: opa_q <= wb_dat_i;
          `FPU_ADDR_OPB: opb_q <= wb_dat_i;
          `FPU_ADDR_OPC: opc_q <= wb_dat_i;
          default: ;
        endcase
      end
      if (issue) begin
        op_q  <= fpu_pkg::fma_op_e'(wb_dat_i[1:0]);
        rnd_q <= fpu_pkg::rnd_mode_e'(wb_dat_i[4:2]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Issue and completion
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q   <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      res_q  <= '0;
      stat_q <= '0;
    end else begin
      // One-cycle pulse, operands are stable by then
      en_q <= issue;
      if (issue) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (res_valid_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (res_valid_i) begin
        res_q  <= res_rsp_i.res;
        stat_q <= res_rsp_i.status;
      end
    end
  end

  assign wb_ack_o  = ack_q;
  assign wb_dat_o  = rdata_q;
  assign fma_en_o  = en_q;
  assign fma_op_o  = op_q;
  assign fma_req_o = '{a: opa_q, b: opb_q, c: opc_q, rnd: rnd_q};

  // Pipe must only return results for an outstanding issue
  a_valid_needs_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> busy_q)
    else $error("FMA result without outstanding operation");

endmodule

`default_nettype wire

//--- src/fma_operand_stage.sv
////////////////////////////////////////////////////////////
// FMA operand stage
// Opcode sign negation and the pre-pipe registers ahead of
// the combinational core
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fpu_defs_defs.svh"

module fma_operand_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  fpu_pkg::fma_req_t  req_i,
  input  fpu_pkg::fma_op_e   op_i,
  output logic               valid_o,
  output fpu_pkg::fma_req_t  req_o
);

  localparam int unsigned NREGS = `FPU_PRE_REGS;

  logic [1:0]         op_bits;
  fpu_pkg::fma_req_t  neg_req;
  // Index 0 is the unregistered input, NREGS the last register
  logic [NREGS:0]     en_pipe;
  fpu_pkg::fma_req_t  req_pipe [NREGS+1];

  assign op_bits = op_i;

  // Zeroed operands keep the core quiet between issues
  always_comb begin
    neg_req     = '0;
    neg_req.rnd = req_i.rnd;
    if (en_i) begin
      neg_req.a = req_i.a;
      neg_req.b = {req_i.b[31] ^ op_bits[1], req_i.b[30:0]};
      neg_req.c = {req_i.c[31] ^ op_bits[0], req_i.c[30:0]};
    end
  end

  assign en_pipe[0]  = en_i;
  assign req_pipe[0] = neg_req;

  for (genvar i = 1; i <= NREGS; i++) begin : g_pre_regs
    // Enable shifts every cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        en_pipe[i] <= 1'b0;
      end else begin
        en_pipe[i] <= en_pipe[i-1];
      end
    end

    // Data only moves along with its enable
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        req_pipe[i] <= '0;
      end else if (en_pipe[i-1]) begin
        req_pipe[i] <= req_pipe[i-1];
      end
    end
  end

  assign valid_o = en_pipe[NREGS];
  assign req_o   = req_pipe[NREGS];

endmodule

`default_nettype wire

//--- src/fma_core.sv
////////////////////////////////////////////////////////////
// FMA core
// Combinational single-precision A*B+C with one rounding,
// flush-to-zero on subnormals and IEEE status flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fma_core (
  input  fpu_pkg::fma_req_t  req_i,
  output fpu_pkg::fma_rsp_t  rsp_o
);

  localparam logic [31:0] QNAN = 32'h7FC0_0000;

  logic [31:0]        opnd [3];
  logic [2:0]         is_zero;
  logic [2:0]         is_inf;
  logic [2:0]         is_nan;
  logic [2:0]         is_snan;
  logic               rtz;
  logic               rdn;
  logic               rup;
  logic               prod_sign;
  logic               c_sign;
  logic               prod_zero;
  logic               prod_inf;
  logic               eff_sub;
  logic [47:0]        prod_mant;
  logic signed [11:0] prod_exp;
  logic signed [11:0] c_exp;
  logic [50:0]        prod_field;
  logic [50:0]        c_field;
  logic               big_sign;
  logic signed [11:0] big_exp;
  logic signed [11:0] exp_diff;
  logic [50:0]        big_f;
  logic [50:0]        small_f;
  logic [50:0]        small_al;
  logic [5:0]         shamt;
  logic               sticky_al;
  logic [51:0]        sum_raw;
  logic [51:0]        sum_mag;
  logic               res_sign;
  logic [5:0]         lz;
  logic [51:0]        norm;
  logic signed [11:0] norm_exp;
  logic signed [11:0] res_exp;
  logic [23:0]        mant_trunc;
  logic               guard;
  logic               sticky;
  logic               inexact;
  logic               round_up;
  logic [24:0]        mant_rnd;
  logic [22:0]        res_frac;

  function automatic logic [5:0] lead_zeros(input logic [51:0] v);
    logic [5:0] n;
    logic       found;
    n     = '0;
    found = 1'b0;
    for (int i = 51; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) found = 1'b1;
        else n = n + 6'd1;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Unpack and classify
  ////////////////////////////////////////////////////////////

  assign opnd[0] = req_i.a;
  assign opnd[1] = req_i.b;
  assign opnd[2] = req_i.c;

  // Zero exponent covers subnormals, which are flushed
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      is_zero[i] = (opnd[i][30:23] == 8'h00);
      is_inf[i]  = (opnd[i][30:23] == 8'hFF) && (opnd[i][22:0] == 23'd0);
      is_nan[i]  = (opnd[i][30:23] == 8'hFF) && (opnd[i][22:0] != 23'd0);
      is_snan[i] = is_nan[i] && !opnd[i][22];
    end
  end

  always_comb begin
    rtz = 1'b0;
    rdn = 1'b0;
    rup = 1'b0;
    case (req_i.rnd)
      fpu_pkg::RTZ: rtz = 1'b1;
      fpu_pkg::RDN: rdn = 1'b1;
      fpu_pkg::RUP: rup = 1'b1;
      default: ;
    endcase
  end

  assign prod_sign = opnd[0][31] ^ opnd[1][31];
  assign c_sign    = opnd[2][31];
  assign eff_sub   = prod_sign ^ c_sign;
  assign prod_zero = is_zero[0] | is_zero[1];
  assign prod_inf  = is_inf[0] | is_inf[1];

  // Exact product, binary point at bit 46
  assign prod_mant = {24'd0, 1'b1, opnd[0][22:0]} * {24'd0, 1'b1, opnd[1][22:0]};
  assign prod_exp  = $signed({4'd0, opnd[0][30:23]}) + $signed({4'd0, opnd[1][30:23]})
                     - 12'sd127;
  assign c_exp     = $signed({4'd0, opnd[2][30:23]});

  // Both fields with three guard bits, point at bit 49
  assign prod_field = {prod_mant, 3'b000};
  assign c_field    = is_zero[2] ? '0 : {2'b01, opnd[2][22:0], 26'd0};

  ////////////////////////////////////////////////////////////
  // Align and add
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (is_zero[2] || (prod_exp >= c_exp)) begin
      big_sign = prod_sign;
      big_exp  = prod_exp;
      exp_diff = prod_exp - c_exp;
      big_f    = prod_field;
      small_f  = c_field;
    end else begin
      big_sign = c_sign;
      big_exp  = c_exp;
      exp_diff = c_exp - prod_exp;
      big_f    = c_field;
      small_f  = prod_field;
    end
    shamt       = (exp_diff > 12'sd63) ? 6'd63 : exp_diff[5:0];
    small_al    = small_f >> shamt;
    // Bits shifted out collapse into the LSB
    sticky_al   = |(small_f & ~({51{1'b1}} << shamt));
    small_al[0] = small_al[0] | sticky_al;
  end

  always_comb begin
    if (eff_sub) sum_raw = {1'b0, big_f} - {1'b0, small_al};
    else sum_raw = {1'b0, big_f} + {1'b0, small_al};
    // Negative difference only when exponents are close
    if (eff_sub && sum_raw[51]) begin
      sum_mag  = -sum_raw;
      res_sign = ~big_sign;
    end else begin
      sum_mag  = sum_raw;
      res_sign = big_sign;
    end
  end

  ////////////////////////////////////////////////////////////
  // Normalize and round
  ////////////////////////////////////////////////////////////

  assign lz         = lead_zeros(sum_mag);
  assign norm       = sum_mag << lz;
  assign norm_exp   = big_exp + 12'sd2 - $signed({6'd0, lz});
  assign mant_trunc = norm[51:28];
  assign guard      = norm[27];
  assign sticky     = |norm[26:0];
  assign inexact    = guard | sticky;

  always_comb begin
    if (rtz) round_up = 1'b0;
    else if (rdn) round_up = res_sign & inexact;
    else if (rup) round_up = ~res_sign & inexact;
    else round_up = guard & (sticky | mant_trunc[0]);
  end

  // Carry out of the mantissa bumps the exponent
  assign mant_rnd = {1'b0, mant_trunc} + {24'd0, round_up};
  assign res_exp  = mant_rnd[24] ? norm_exp + 12'sd1 : norm_exp;
  assign res_frac = mant_rnd[24] ? mant_rnd[23:1] : mant_rnd[22:0];

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    rsp_o = '0;
    if (|is_nan) begin
      rsp_o.res       = QNAN;
      rsp_o.status.nv = |is_snan;
    end else if ((prod_inf && prod_zero) || (prod_inf && is_inf[2] && eff_sub)) begin
      // Inf times zero, or opposite infinities
      rsp_o.res       = QNAN;
      rsp_o.status.nv = 1'b1;
    end else if (prod_inf) begin
      rsp_o.res = {prod_sign, 8'hFF, 23'd0};
    end else if (is_inf[2]) begin
      rsp_o.res = {c_sign, 8'hFF, 23'd0};
    end else if (prod_zero && is_zero[2]) begin
      rsp_o.res = {(eff_sub ? rdn : prod_sign), 31'd0};
    end else if (prod_zero) begin
      rsp_o.res = opnd[2];
    end else if (sum_mag == 52'd0) begin
      // Exact cancellation is +0 except when rounding down
      rsp_o.res = {rdn, 31'd0};
    end else if (res_exp >= 12'sd255) begin
      rsp_o.status.of = 1'b1;
      rsp_o.status.nx = 1'b1;
      if (rtz || (rdn && !res_sign) || (rup && res_sign)) begin
        rsp_o.res = {res_sign, 31'h7F7F_FFFF};
      end else begin
        rsp_o.res = {res_sign, 8'hFF, 23'd0};
      end
    end else if (res_exp <= 12'sd0) begin
      // Tiny result flushed to signed zero
      rsp_o.res       = {res_sign, 31'd0};
      rsp_o.status.uf = 1'b1;
      rsp_o.status.nx = 1'b1;
    end else begin
      rsp_o.res       = {res_sign, res_exp[7:0], res_frac};
      rsp_o.status.nx = inexact;
    end
  end

endmodule

`default_nettype wire

//--- src/fma_result_stage.sv
////////////////////////////////////////////////////////////
// FMA result stage
// Post-pipe register for result and status flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fma_result_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  fpu_pkg::fma_rsp_t  rsp_i,
  output logic               valid_o,
  output fpu_pkg::fma_rsp_t  rsp_o
);

  logic               valid_q;
  fpu_pkg::fma_rsp_t  rsp_q;

  // Valid tracks the enable that came down the pipe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= en_i;
    end
  end

  // Response held between operations
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else if (en_i) begin
      rsp_q <= rsp_i;
    end
  end

  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

  // Busy bit in the slave keeps results at least one cycle apart
  a_single_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q |=> !valid_q)
    else $error("back-to-back FMA results");

endmodule

`default_nettype wire

//--- src/fpu_top.sv
////////////////////////////////////////////////////////////
// FPU top
// Wishbone slave, operand pipe, FMA core and result register
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fpu_top (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  logic               fma_en;
  fpu_pkg::fma_req_t  fma_req;
  fpu_pkg::fma_op_e   fma_op;
  logic               op_valid;
  fpu_pkg::fma_req_t  op_req;
  fpu_pkg::fma_rsp_t  core_rsp;
  logic               res_valid;
  fpu_pkg::fma_rsp_t  res_rsp;

  fpu_wb_slave u_slave (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .fma_en_o    (fma_en),
    .fma_req_o   (fma_req),
    .fma_op_o    (fma_op),
    .res_valid_i (res_valid),
    .res_rsp_i   (res_rsp)
  );

  fma_operand_stage u_operand (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (fma_en),
    .req_i   (fma_req),
    .op_i    (fma_op),
    .valid_o (op_valid),
    .req_o   (op_req)
  );

  fma_core u_core (
    .req_i (op_req),
    .rsp_o (core_rsp)
  );

  fma_result_stage u_result (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (op_valid),
    .rsp_i   (core_rsp),
    .valid_o (res_valid),
    .rsp_o   (res_rsp)
  );

endmodule

`default_nettype wire

//--- dv/tb_fpu_top.sv
////////////////////////////////////////////////////////////
// FPU testbench
// Drives the Wishbone slave of the FMA unit and checks
// results and flags against a real-valued reference
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fpu_defs_defs.svh"

module tb_fpu_top;

  localparam int unsigned BUS_TIMEOUT  = 20;
  localparam int unsigned DONE_TIMEOUT = 50;
  localparam int unsigned NUM_RANDOM   = 24;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned n_timeouts;

  fpu_top uut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Normal numbers only, exponent zero reads as zero
  function automatic real bits_to_real(input logic [31:0] f);
    real v;
    int  e;
    if (f[30:23] == 8'h00) return 0.0;
    v = 1.0 + $itor(f[22:0]) / 8388608.0;
    e = int'(f[30:23]) - 127;
    while (e > 0) begin
      v = v * 2.0;
      e--;
    end
    while (e < 0) begin
      v = v / 2.0;
      e++;
    end
    return f[31] ? -v : v;
  endfunction

  // Exact values only, so no rounding step
  function automatic logic [31:0] real_to_bits(input real v);
    logic       s;
    real        m;
    int         e;
    int         frac;
    logic [7:0] ex;
    if (v == 0.0) return 32'h0000_0000;
    s = (v < 0.0);
    m = s ? -v : v;
    e = 0;
    while (m >= 2.0) begin
      m = m / 2.0;
      e++;
    end
    while (m < 1.0) begin
      m = m * 2.0;
      e--;
    end
    frac = $rtoi((m - 1.0) * 8388608.0);
    ex   = 8'(e + 127);
    return {s, ex, frac[22:0]};
  endfunction

  // Opcode bit 1 negates B, bit 0 negates C
  function automatic logic [31:0] ref_fma(input logic [31:0] a, input logic [31:0] b,
                                          input logic [31:0] c, input fpu_pkg::fma_op_e op);
    logic [1:0] ob;
    real        ra;
    real        rb;
    real        rc;
    ob = op;
    ra = bits_to_real(a);
    rb = bits_to_real(b);
    rc = bits_to_real(c);
    if (ob[1]) rb = -rb;
    if (ob[0]) rc = -rc;
    return real_to_bits(ra * rb + rc);
  endfunction

  // Small integer times a power of two, keeps sums exact
  function automatic logic [31:0] rand_operand();
    int  mag;
    int  sh;
    real v;
    mag = 1 + int'($urandom % 15);
    sh  = int'($urandom % 5) - 2;
    v   = $itor(mag);
    while (sh > 0) begin
      v = v * 2.0;
      sh--;
    end
    while (sh < 0) begin
      v = v / 2.0;
      sh++;
    end
    if ($urandom % 2) v = -v;
    return real_to_bits(v);
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_res(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("ERR %s expected %08h actual %08h", name, exp_v, act_v);
    end
  endtask

  task automatic check_status(input string name, input fpu_pkg::fp_status_t exp_v,
                              input fpu_pkg::fp_status_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("ERR %s expected %05b actual %05b", name, exp_v, act_v);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone tasks
  ////////////////////////////////////////////////////////////

  // Ack is sampled 2 ns after the edge, then the cycle ends
  task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
    int unsigned n;
    logic        ok;
    @(posedge clk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < BUS_TIMEOUT) begin
      @(posedge clk);
      #2;
      n++;
      ok = wb_ack;
    end
    if (!ok) begin
      n_timeouts++;
      $display("Timeout: no ack for write to offset %02h", adr);
    end
    // Ack belongs on the first edge after the request
    if (ok && n != 1) begin
      n_errors++;
      $display("Ack for write to offset %02h arrived after %0d cycles", adr, n);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
    int unsigned n;
    logic        ok;
    @(posedge clk);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    n   = 0;
    ok  = 1'b0;
    dat = '0;
    while (!ok && n < BUS_TIMEOUT) begin
      @(posedge clk);
      #2;
      n++;
      ok = wb_ack;
    end
    if (ok) dat = wb_dat_r;
    else begin
      n_timeouts++;
      $display("Timeout: no ack for read from offset %02h", adr);
    end
    if (ok && n != 1) begin
      n_errors++;
      $display("Ack for read from offset %02h arrived after %0d cycles", adr, n);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Poll STAT until the done bit shows up
  task automatic wait_done(output logic [31:0] stat);
    int unsigned n;
    n    = 0;
    stat = '0;
    while (!stat[1] && n < DONE_TIMEOUT) begin
      wb_read(`FPU_ADDR_STAT, stat);
      n++;
    end
    if (!stat[1]) begin
      n_timeouts++;
      $display("Timeout: done bit never set after CTRL write");
    end
  endtask

  task automatic run_fma(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                         input fpu_pkg::fma_op_e op, input fpu_pkg::rnd_mode_e rnd,
                         output logic [31:0] res, output fpu_pkg::fp_status_t st);
    logic [31:0] stat;
    wb_write(`FPU_ADDR_OPA, a);
    wb_write(`FPU_ADDR_OPB, b);
    wb_write(`FPU_ADDR_OPC, c);
    wb_write(`FPU_ADDR_CTRL, {27'd0, rnd, op});
    wait_done(stat);
    st = fpu_pkg::fp_status_t'(stat[6:2]);
    wb_read(`FPU_ADDR_RES, res);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]         rd;
    logic [31:0]         res;
    logic [31:0]         exp_res;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [31:0]         c;
    fpu_pkg::fp_status_t st;
    fpu_pkg::fma_op_e    op;

    void'($urandom(32'h6764));
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_sel     = 4'hF;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Bus state after reset
    wb_read(`FPU_ADDR_STAT, rd);
    check_res("stat_after_reset", 32'h0, rd);
    wb_read(`FPU_ADDR_RES, rd);
    check_res("res_after_reset", 32'h0, rd);

    // Operand readback
    wb_write(`FPU_ADDR_OPA, 32'h1234_5678);
    wb_write(`FPU_ADDR_OPB, 32'hA5A5_0F0F);
    wb_write(`FPU_ADDR_OPC, 32'h8000_0001);
    wb_read(`FPU_ADDR_OPA, rd);
    check_res("readback_opa", 32'h1234_5678, rd);
    wb_read(`FPU_ADDR_OPB, rd);
    check_res("readback_opb", 32'hA5A5_0F0F, rd);
    wb_read(`FPU_ADDR_OPC, rd);
    check_res("readback_opc", 32'h8000_0001, rd);

    // 2 * 3 + 1 with each sign rule
    run_fma(32'h4000_0000, 32'h4040_0000, 32'h3F80_0000, fpu_pkg::FMADD, fpu_pkg::RNE, res, st);
    check_res("op_fmadd", 32'h40E0_0000, res);
    check_status("op_fmadd_flags", '0, st);
    run_fma(32'h4000_0000, 32'h4040_0000, 32'h3F80_0000, fpu_pkg::FMSUB, fpu_pkg::RNE, res, st);
    check_res("op_fmsub", 32'h40A0_0000, res);
    check_status("op_fmsub_flags", '0, st);
    run_fma(32'h4000_0000, 32'h4040_0000, 32'h3F80_0000, fpu_pkg::FNMSUB, fpu_pkg::RNE, res, st);
    check_res("op_fnmsub", 32'hC0A0_0000, res);
    check_status("op_fnmsub_flags", '0, st);
    run_fma(32'h4000_0000, 32'h4040_0000, 32'h3F80_0000, fpu_pkg::FNMADD, fpu_pkg::RNE, res, st);
    check_res("op_fnmadd", 32'hC0E0_0000, res);
    check_status("op_fnmadd_flags", '0, st);

    // 1 + 2^-30 in every rounding mode, only RUP moves the LSB
    run_fma(32'h3F80_0000, 32'h3F80_0000, 32'h3080_0000, fpu_pkg::FMADD, fpu_pkg::RNE, res, st);
    check_res("round_rne", 32'h3F80_0000, res);
    check_status("round_rne_flags", 5'b00001, st);
    run_fma(32'h3F80_0000, 32'h3F80_0000, 32'h3080_0000, fpu_pkg::FMADD, fpu_pkg::RTZ, res, st);
    check_res("round_rtz", 32'h3F80_0000, res);
    check_status("round_rtz_flags", 5'b00001, st);
    run_fma(32'h3F80_0000, 32'h3F80_0000, 32'h3080_0000, fpu_pkg::FMADD, fpu_pkg::RDN, res, st);
    check_res("round_rdn", 32'h3F80_0000, res);
    check_status("round_rdn_flags", 5'b00001, st);
    run_fma(32'h3F80_0000, 32'h3F80_0000, 32'h3080_0000, fpu_pkg::FMADD, fpu_pkg::RUP, res, st);
    check_res("round_rup", 32'h3F80_0001, res);
    check_status("round_rup_flags", 5'b00001, st);

    // Overflow, invalid and flushed tiny product
    run_fma(32'h7F7F_FFFF, 32'h4000_0000, 32'h0000_0000, fpu_pkg::FMADD, fpu_pkg::RNE, res, st);
    check_res("special_overflow", 32'h7F80_0000, res);
    check_status("special_overflow_flags", 5'b00101, st);
    run_fma(32'h7F80_0000, 32'h0000_0000, 32'h3F80_0000, fpu_pkg::FMADD, fpu_pkg::RNE, res, st);
    check_res("special_inf_times_zero", 32'h7FC0_0000, res);
    check_status("special_inf_times_zero_flags", 5'b10000, st);
    run_fma(32'h1C80_0000, 32'h1C80_0000, 32'h0000_0000, fpu_pkg::FMADD, fpu_pkg::RNE, res, st);
    check_res("special_tiny", 32'h0000_0000, res);
    check_status("special_tiny_flags", 5'b00011, st);

    // Second CTRL write lands while busy and must be dropped
    wb_write(`FPU_ADDR_OPA, 32'h4000_0000);
    wb_write(`FPU_ADDR_OPB, 32'h4040_0000);
    wb_write(`FPU_ADDR_OPC, 32'h3F80_0000);
    wb_write(`FPU_ADDR_CTRL, {27'd0, fpu_pkg::RNE, fpu_pkg::FMADD});
    wb_write(`FPU_ADDR_CTRL, {27'd0, fpu_pkg::RTZ, fpu_pkg::FNMADD});
    wait_done(rd);
    check_res("busy_stat_done", 32'h0000_0002, rd);
    wb_read(`FPU_ADDR_RES, rd);
    check_res("busy_first_result", 32'h40E0_0000, rd);
    wb_read(`FPU_ADDR_CTRL, rd);
    check_res("busy_ctrl_kept", 32'h0000_0000, rd);
    // Nothing else may come out of the pipe
    repeat (8) @(posedge clk);
    wb_read(`FPU_ADDR_STAT, rd);
    check_res("busy_stat_stable", 32'h0000_0002, rd);
    wb_read(`FPU_ADDR_RES, rd);
    check_res("busy_result_stable", 32'h40E0_0000, rd);

    // Random exact cases under RNE
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a       = rand_operand();
      b       = rand_operand();
      c       = rand_operand();
      op      = fpu_pkg::fma_op_e'(2'($urandom % 4));
      exp_res = ref_fma(a, b, c, op);
      run_fma(a, b, c, op, fpu_pkg::RNE, res, st);
      check_res($sformatf("random_%0d", i), exp_res, res);
      check_status($sformatf("random_%0d_flags", i), '0, st);
    end

    $display("Summary: %0d checks, %0d errors, %0d timeouts", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
src/fpu_pkg.sv
src/fpu_wb_slave.sv
src/fma_operand_stage.sv
src/fma_core.sv
src/fma_result_stage.sv
src/fpu_top.sv
dv/tb_fpu_top.sv

//--- Makefile
# Verilator build and run for the FMA unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
